//--- include/mac_defines.svh
`ifndef MAC_DEFINES_SVH
`define MAC_DEFINES_SVH

// ====================================================================
// memory map
// ====================================================================

// word offset inside one region
`define MEM_OFFSET_BITS 10
// region select on top of the offset
`define MEM_REGION_BITS 2
`define MEM_ADDR_BITS (`MEM_REGION_BITS + `MEM_OFFSET_BITS)
`define MEM_WORDS (1 << `MEM_ADDR_BITS)

// region codes
`define REGION_RAM 2'd0
`define REGION_ROM 2'd1
`define REGION_DISK_INT 2'd2
`define REGION_DISK_EXT 2'd3

// host download port
`define DL_INDEX_BITS 8
`define DL_ADDR_BITS 24

// ====================================================================
// scaled sizes and hold counts
// ====================================================================

// final word counts of a valid floppy image
`define DISK_DS_WORDS 512
`define DISK_SS_WORDS 256

// phase-4 strobes after the last reset source
`define RESET_HOLD 16
// falling disk acks before turbo is allowed
`define TURBO_ACK_HOLD 20
// cycles the activity flag lasts after an act bit
`define DISK_ACT_HOLD 64
// cycles in one arbiter round
`define SLOT_CYCLES 8

`endif

//--- sim.f
+incdir+include
src/mac_mem_pkg.sv
src/memory_slot_arbiter.sv
src/rom_download_loader.sv
src/floppy_image_tracker.sv
src/word_memory.sv
src/system_control.sv
src/mac_memory_top.sv
verification/mac_memory_tb.sv

//--- src/floppy_image_tracker.sv
`timescale 1ns/1ns
`include "mac_defines.svh"

module floppy_image_tracker
	import mac_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       n_reset,
	input  logic       download,
	input  dl_byte_t   dl,
	input  disk_ctrl_t disk,
	output logic [1:0] disk_inserted,
	output logic [1:0] disk_sides,
	output logic       led_user
);
	localparam int ACT_BITS = $clog2(`DISK_ACT_HOLD + 1);

	logic down_q;
	logic dl_end;
	logic [`DL_ADDR_BITS-1:0] last_addr;
	logic [`DL_INDEX_BITS-1:0] last_index;
	logic [`DL_ADDR_BITS-1:0] final_words;
	logic is_ds;
	logic is_ss;
	logic [1:0] ins_q;
	logic [1:0] sides_q;
	logic [ACT_BITS-1:0] act_cnt;
	logic act_flag;

	// ====================================================================
	// image size detection
	// ====================================================================

	// last byte seen by the loader
	always_ff @(posedge clk_sys) begin
		if (dl.wr) begin
			last_addr <= dl.addr;
			last_index <= dl.index;
		end
	end

	// byte count is the last address plus one, then halved to words
	assign final_words = (last_addr + `DL_ADDR_BITS'(1)) >> 1;
	assign is_ds = (final_words == `DL_ADDR_BITS'(`DISK_DS_WORDS));
	assign is_ss = (final_words == `DL_ADDR_BITS'(`DISK_SS_WORDS));
	assign dl_end = down_q && !download;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			down_q <= 1'b0;
			ins_q <= 2'b00;
			sides_q <= 2'b00;
		end else begin
			down_q <= download;
			// drive 0 takes index 1, drive 1 takes index 2
			for (int d = 0; d < 2; d++) begin
				if (disk.eject[d]) begin
					ins_q[d] <= 1'b0;
					sides_q[d] <= 1'b0;
				end else if (dl_end && last_index == `DL_INDEX_BITS'(d + 1)) begin
					// unknown size means no disk
					ins_q[d] <= is_ds || is_ss;
					sides_q[d] <= is_ds;
				end
			end
		end
	end

	assign disk_inserted = ins_q;
	assign disk_sides = sides_q;

	// ====================================================================
	// activity led
	// ====================================================================

	// retriggered by every act bit
	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			act_cnt <= '0;
			act_flag <= 1'b0;
		end else begin
			act_flag <= (act_cnt != '0);
			if (act_cnt != '0)
				act_cnt <= act_cnt - ACT_BITS'(1);
			if (|disk.act)
				act_cnt <= ACT_BITS'(`DISK_ACT_HOLD);
		end
	end

	// motor on inverts the led so activity still blinks
	assign led_user = download || (act_flag ^ (|disk.motor));

endmodule

//--- src/mac_mem_pkg.sv
`include "mac_defines.svh"

package mac_mem_pkg;

	// cpu side request, held with valid high until ack
	typedef struct packed {
		logic valid;
		logic write;
		logic [`MEM_REGION_BITS-1:0] region;
		logic [`MEM_OFFSET_BITS-1:0] offset;
		// byte address bit 0, picks the byte on disk reads
		logic byte_sel;
		// bit 1 upper lane, bit 0 lower lane
		logic [1:0] lanes;
		logic [15:0] wdata;
	} cpu_req_t;

	// ack is a single cycle pulse
	typedef struct packed {
		logic ack;
		logic [15:0] rdata;
	} cpu_rsp_t;

	// one byte from the host image loader
	typedef struct packed {
		logic wr;
		logic [`DL_INDEX_BITS-1:0] index;
		logic [`DL_ADDR_BITS-1:0] addr;
		logic [7:0] data;
	} dl_byte_t;

	// one word memory access, valid for a single cycle
	typedef struct packed {
		logic we;
		logic re;
		logic [`MEM_ADDR_BITS-1:0] addr;
		logic [1:0] be;
		logic [15:0] wdata;
	} mem_req_t;

	// reset and speed controls from the host side
	typedef struct packed {
		logic osd_reset;
		logic user_button;
		// low means the cpu asks for a reset
		logic cpu_reset_out;
		logic turbo_request;
	} host_ctrl_t;

	// floppy controller status, one bit per drive
	typedef struct packed {
		logic [1:0] eject;
		logic [1:0] motor;
		logic [1:0] act;
	} disk_ctrl_t;

endpackage

//--- src/mac_memory_top.sv
`timescale 1ns/1ns

module mac_memory_top
	import mac_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       n_reset,
	input  dl_byte_t   dl,
	input  logic       download,
	input  cpu_req_t   cpu_req,
	input  host_ctrl_t host,
	input  disk_ctrl_t disk,
	input  logic       disk_ack,
	output cpu_rsp_t   cpu_rsp,
	output logic       host_wait,
	output logic [1:0] disk_inserted,
	output logic [1:0] disk_sides,
	output logic       led_user,
	output logic       turbo_active
);
	// ====================================================================
	// internal wires
	// ====================================================================

	mem_req_t loader_req;
	mem_req_t mem_req;
	logic [15:0] mem_rdata;
	logic loader_round;
	logic phase4;
	logic system_ready;

	memory_slot_arbiter memory_slot_arbiter_inst (
		.clk_sys(clk_sys),
		.n_reset(n_reset),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp),
		.loader_req(loader_req),
		.loader_round(loader_round),
		.system_ready(system_ready),
		.mem_req(mem_req),
		.mem_rdata(mem_rdata),
		.phase4(phase4)
	);

	rom_download_loader rom_download_loader_inst (
		.clk_sys(clk_sys),
		.n_reset(n_reset),
		.dl(dl),
		.loader_round(loader_round),
		.loader_req(loader_req),
		.host_wait(host_wait)
	);

	floppy_image_tracker floppy_image_tracker_inst (
		.clk_sys(clk_sys),
		.n_reset(n_reset),
		.download(download),
		.dl(dl),
		.disk(disk),
		.disk_inserted(disk_inserted),
		.disk_sides(disk_sides),
		.led_user(led_user)
	);

	word_memory word_memory_inst (
		.clk_sys(clk_sys),
		.mem_req(mem_req),
		.rdata(mem_rdata)
	);

	system_control system_control_inst (
		.clk_sys(clk_sys),
		.n_reset(n_reset),
		.host(host),
		.disk(disk),
		.disk_ack(disk_ack),
		.phase4(phase4),
		.loader_round(loader_round),
		.system_ready(system_ready),
		.turbo_active(turbo_active)
	);

endmodule

//--- src/memory_slot_arbiter.sv
`timescale 1ns/1ns
`include "mac_defines.svh"

module memory_slot_arbiter
	import mac_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        n_reset,
	input  cpu_req_t    cpu_req,
	output cpu_rsp_t    cpu_rsp,
	input  mem_req_t    loader_req,
	output logic        loader_round,
	input  logic        system_ready,
	output mem_req_t    mem_req,
	input  logic [15:0] mem_rdata,
	output logic        phase4
);
	localparam int PHASE_BITS = $clog2(`SLOT_CYCLES);
	localparam int SAMPLE_PHASE = 4;
	// ack is visible in the last phase of the round
	localparam int CAPTURE_PHASE = `SLOT_CYCLES - 2;

	logic [PHASE_BITS-1:0] phase;
	logic cpu_grant;
	logic cpu_served;
	logic served_disk;
	logic served_byte_sel;
	logic rsp_ack;
	logic [15:0] rsp_rdata;
	logic [15:0] ret_data;
	mem_req_t cpu_mem_req;

	// ====================================================================
	// round timing
	// ====================================================================

	assign phase4 = (phase == PHASE_BITS'(SAMPLE_PHASE));

	// cpu only gets the slot once the system is out of reset
	assign cpu_grant = !loader_round && phase4 && cpu_req.valid && system_ready;

	// ====================================================================
	// request mux
	// ====================================================================

	// rom and disk are read only for the cpu, the write is dropped but acked
	assign cpu_mem_req.we = cpu_req.write && (cpu_req.region == `REGION_RAM);
	assign cpu_mem_req.re = !cpu_req.write;
	assign cpu_mem_req.addr = {cpu_req.region, cpu_req.offset};
	assign cpu_mem_req.be = cpu_req.lanes;
	assign cpu_mem_req.wdata = cpu_req.wdata;

	// memory sees at most one access per round, always at phase 4
	always_comb begin
		mem_req = '0;
		if (phase4) begin
			if (loader_round)
				mem_req = loader_req;
			else if (cpu_grant)
				mem_req = cpu_mem_req;
		end
	end

	// ====================================================================
	// read return
	// ====================================================================

	// disk images are byte wide, so the selected byte goes out on both lanes
	always_comb begin
		ret_data = mem_rdata;
		if (served_disk) begin
			if (served_byte_sel)
				ret_data = {mem_rdata[7:0], mem_rdata[7:0]};
			else
				ret_data = {mem_rdata[15:8], mem_rdata[15:8]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			phase <= '0;
			loader_round <= 1'b0;
			cpu_served <= 1'b0;
			rsp_ack <= 1'b0;
		end else begin
			// phase counter wraps every round, owner flips on the wrap
			if (phase == PHASE_BITS'(`SLOT_CYCLES - 1)) begin
				phase <= '0;
				loader_round <= !loader_round;
			end else begin
				phase <= phase + PHASE_BITS'(1);
			end
			rsp_ack <= 1'b0;
			if (cpu_grant)
				cpu_served <= 1'b1;
			if (phase == PHASE_BITS'(CAPTURE_PHASE) && cpu_served) begin
				rsp_ack <= 1'b1;
				cpu_served <= 1'b0;
			end
		end
	end

	// what kind of return the served access needs
	always_ff @(posedge clk_sys) begin
		if (cpu_grant) begin
			served_disk <= (cpu_req.region == `REGION_DISK_INT) ||
				(cpu_req.region == `REGION_DISK_EXT);
			served_byte_sel <= cpu_req.byte_sel;
		end
		// memory data is valid from phase 5
		if (phase == PHASE_BITS'(CAPTURE_PHASE))
			rsp_rdata <= ret_data;
	end

	assign cpu_rsp.ack = rsp_ack;
	assign cpu_rsp.rdata = rsp_rdata;

endmodule

//--- src/rom_download_loader.sv
`timescale 1ns/1ns
`include "mac_defines.svh"

module rom_download_loader
	import mac_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     n_reset,
	input  dl_byte_t dl,
	input  logic     loader_round,
	output mem_req_t loader_req,
	output logic     host_wait
);
	logic [7:0] high_byte;
	logic [`MEM_REGION_BITS-1:0] region;
	logic [`MEM_ADDR_BITS-1:0] word_addr;
	logic [15:0] word_data;
	// a completed word waits for memory
	logic wait_q;
	// pending word has seen a cpu round and owns the next loader round
	logic armed;
	logic round_q;
	logic round_done;

	// ====================================================================
	// download index to region
	// ====================================================================

	always_comb begin
		case (dl.index)
			`DL_INDEX_BITS'd1: region = `REGION_DISK_INT;
			`DL_INDEX_BITS'd2: region = `REGION_DISK_EXT;
			// os rom and anything unknown
			default: region = `REGION_ROM;
		endcase
	end

	// ====================================================================
	// byte pairing
	// ====================================================================

	// even byte is the high half, odd byte completes the word
	always_ff @(posedge clk_sys) begin
		if (dl.wr) begin
			if (!dl.addr[0]) begin
				high_byte <= dl.data;
			end else begin
				word_data <= {high_byte, dl.data};
				// word offset is the byte address halved
				word_addr <= {region, dl.addr[`MEM_OFFSET_BITS:1]};
			end
		end
	end

	// ====================================================================
	// wait level
	// ====================================================================

	// loader round that carried the write has just ended
	assign round_done = round_q && !loader_round && armed;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			wait_q <= 1'b0;
			armed <= 1'b0;
			round_q <= 1'b0;
		end else begin
			round_q <= loader_round;
			if (round_done) begin
				wait_q <= 1'b0;
				armed <= 1'b0;
			end else if (wait_q && !loader_round) begin
				// only arm in a cpu round so the write never lands mid round
				armed <= 1'b1;
			end
			if (dl.wr && dl.addr[0])
				wait_q <= 1'b1;
		end
	end

	// drops in the first cpu cycle after the write round
	assign host_wait = wait_q && !round_done;

	// arbiter samples this at phase 4 of the loader round
	assign loader_req.we = armed;
	assign loader_req.re = 1'b0;
	assign loader_req.addr = word_addr;
	assign loader_req.be = 2'b11;
	assign loader_req.wdata = word_data;

endmodule

//--- src/system_control.sv
`timescale 1ns/1ns
`include "mac_defines.svh"

module system_control
	import mac_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       n_reset,
	input  host_ctrl_t host,
	input  disk_ctrl_t disk,
	input  logic       disk_ack,
	input  logic       phase4,
	input  logic       loader_round,
	output logic       system_ready,
	output logic       turbo_active
);
	localparam int HOLD_BITS = $clog2(`RESET_HOLD + 1);
	localparam int ACK_BITS = $clog2(`TURBO_ACK_HOLD + 1);

	logic reset_req;
	logic [HOLD_BITS-1:0] hold_cnt;
	logic ready_q;
	logic ack_q;
	logic ack_fall;
	logic [ACK_BITS-1:0] ack_cnt;
	logic turbo_q;

	// ====================================================================
	// reset hold
	// ====================================================================

	// any of these restarts the hold
	assign reset_req = !n_reset || host.osd_reset || host.user_button ||
		!host.cpu_reset_out;

	always_ff @(posedge clk_sys) begin
		if (reset_req) begin
			hold_cnt <= HOLD_BITS'(`RESET_HOLD);
			ready_q <= 1'b0;
		end else if (hold_cnt != '0) begin
			// one step per round
			if (phase4)
				hold_cnt <= hold_cnt - HOLD_BITS'(1);
		end else begin
			ready_q <= 1'b1;
		end
	end

	assign system_ready = ready_q;

	// ====================================================================
	// turbo delay
	// ====================================================================

	// boot disk traffic has to pass before the cpu speeds up
	always_ff @(posedge clk_sys) begin
		if (!n_reset)
			ack_q <= 1'b0;
		else
			ack_q <= disk_ack;
	end

	assign ack_fall = ack_q && !disk_ack;

	always_ff @(posedge clk_sys) begin
		if (!n_reset || !ready_q) begin
			turbo_q <= 1'b0;
			ack_cnt <= ACK_BITS'(`TURBO_ACK_HOLD);
		end else begin
			// count finished disk transfers
			if (ack_fall && ack_cnt != '0)
				ack_cnt <= ack_cnt - ACK_BITS'(1);
			// floppy in use means no hard disk boot to protect
			if (|disk.motor)
				ack_cnt <= '0;
			// speed changes only while the loader owns the memory
			if (ack_cnt == '0 && loader_round)
				turbo_q <= host.turbo_request;
		end
	end

	assign turbo_active = turbo_q;

endmodule

//--- src/word_memory.sv
`timescale 1ns/1ns
`include "mac_defines.svh"

module word_memory
	import mac_mem_pkg::*;
(
	input  logic        clk_sys,
	input  mem_req_t    mem_req,
	output logic [15:0] rdata
);
	// ram, rom and both disk images side by side
	logic [15:0] mem [0:`MEM_WORDS-1];

	// ====================================================================
	// byte lane writes
	// ====================================================================

	always_ff @(posedge clk_sys) begin
		if (mem_req.we) begin
			// upper lane
			if (mem_req.be[1])
				mem[mem_req.addr][15:8] <= mem_req.wdata[15:8];
			// lower lane
			if (mem_req.be[0])
				mem[mem_req.addr][7:0] <= mem_req.wdata[7:0];
		end
	end

	// ====================================================================
	// registered read
	// ====================================================================

	// data holds until the next read
	always_ff @(posedge clk_sys) begin
		if (mem_req.re)
			rdata <= mem[mem_req.addr];
	end

endmodule

//--- verification/mac_memory_tb.sv
`timescale 1ns/1ns
`include "mac_defines.svh"

module mac_memory_tb
	import mac_mem_pkg::*;
();
	localparam int CLK_PERIOD = 20;
	// worst case cpu wait covers a full reset hold
	localparam int ACCESS_CYCLES = (`RESET_HOLD + 4) * `SLOT_CYCLES;
	// byte pairing plus one cpu and one loader round
	localparam int WAIT_FALL_CYCLES = 4 * `SLOT_CYCLES;

	// rounds each test needs at worst
	localparam int ROM_ROUNDS = `RESET_HOLD + 4 + 8 * 4 + 10 * 3;
	localparam int IMAGE_ROUNDS = (`DISK_DS_WORDS + `DISK_SS_WORDS + 3) * 4 + 8;
	localparam int RAM_ROUNDS = 20 * 3;
	localparam int GATE_ROUNDS = `RESET_HOLD + 6;
	localparam int TURBO_ROUNDS = `TURBO_ACK_HOLD + `RESET_HOLD + 12;
	localparam int LED_ROUNDS = (3 * `DISK_ACT_HOLD) / `SLOT_CYCLES + 8;
	localparam int TOTAL_ROUNDS = ROM_ROUNDS + IMAGE_ROUNDS + RAM_ROUNDS +
		GATE_ROUNDS + TURBO_ROUNDS + LED_ROUNDS;
	// twice the summed length as margin
	localparam int WATCHDOG_NS = TOTAL_ROUNDS * `SLOT_CYCLES * CLK_PERIOD * 2;

	logic clk_sys;
	logic n_reset;
	dl_byte_t dl;
	logic download;
	cpu_req_t cpu_req;
	host_ctrl_t host;
	disk_ctrl_t disk;
	logic disk_ack;
	cpu_rsp_t cpu_rsp;
	logic host_wait;
	logic [1:0] disk_inserted;
	logic [1:0] disk_sides;
	logic led_user;
	logic turbo_active;

	// expected word contents, indexed by region and offset
	logic [15:0] model [0:`MEM_WORDS-1];
	logic [1:0] exp_inserted;
	logic [1:0] exp_sides;

	mac_memory_top mac_memory_top_inst (
		.clk_sys(clk_sys),
		.n_reset(n_reset),
		.dl(dl),
		.download(download),
		.cpu_req(cpu_req),
		.host(host),
		.disk(disk),
		.disk_ack(disk_ack),
		.cpu_rsp(cpu_rsp),
		.host_wait(host_wait),
		.disk_inserted(disk_inserted),
		.disk_sides(disk_sides),
		.led_user(led_user),
		.turbo_active(turbo_active)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ====================================================================
	// error reporting and compares
	// ====================================================================

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	// read data of one cpu access
	task automatic check_rsp(input string name, input cpu_rsp_t got, input logic [15:0] exp);
		if (got.rdata !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h",
				name, got.rdata, exp));
	endtask

	// one bit per drive
	task automatic check_flags(input string name, input logic [1:0] got,
		input logic [1:0] exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog expired before the tests finished");
	end

	// ====================================================================
	// reference rules
	// ====================================================================

	function automatic logic [1:0] region_of(input logic [7:0] index);
		case (index)
			8'd1: region_of = `REGION_DISK_INT;
			8'd2: region_of = `REGION_DISK_EXT;
			default: region_of = `REGION_ROM;
		endcase
	endfunction

	function automatic logic [`MEM_ADDR_BITS-1:0] word_index(input logic [1:0] region,
		input int offset);
		word_index = {region, `MEM_OFFSET_BITS'(offset)};
	endfunction

	// {inserted, double sided} from the final word count
	function automatic logic [1:0] image_class(input int n_words);
		if (n_words == `DISK_DS_WORDS)
			image_class = 2'b11;
		else if (n_words == `DISK_SS_WORDS)
			image_class = 2'b10;
		else
			image_class = 2'b00;
	endfunction

	// bit 1 is the upper lane and bit 0 the lower lane
	function automatic logic [15:0] merge_lanes(input logic [15:0] old_word,
		input logic [15:0] new_word, input logic [1:0] lanes);
		merge_lanes = old_word;
		if (lanes[1])
			merge_lanes[15:8] = new_word[15:8];
		if (lanes[0])
			merge_lanes[7:0] = new_word[7:0];
	endfunction

	// ====================================================================
	// bus tasks enter and leave at a falling edge
	// ====================================================================

	task automatic wait_host_wait(input logic level, input int max_cycles, input string what);
		int n;
		n = 0;
		while (host_wait !== level && n < max_cycles) begin
			@(negedge clk_sys);
			n++;
		end
		if (host_wait !== level)
			report_failure($sformatf("timed out waiting for %s", what));
	endtask

	task automatic send_byte(input logic [7:0] index, input int addr, input logic [7:0] data);
		// the host holds off while the loader is busy
		wait_host_wait(1'b0, WAIT_FALL_CYCLES, "host_wait to fall before a byte");
		dl.wr = 1'b1;
		dl.index = index;
		dl.addr = `DL_ADDR_BITS'(addr);
		dl.data = data;
		@(negedge clk_sys);
		dl.wr = 1'b0;
	endtask

	// random image of n_words words, even byte first
	task automatic send_image(input logic [7:0] index, input int n_words);
		logic [7:0] hi;
		logic [7:0] lo;
		logic [1:0] cls;
		int w;
		download = 1'b1;
		@(negedge clk_sys);
		check_level("led_user", led_user, 1'b1);
		for (w = 0; w < n_words; w++) begin
			hi = 8'($urandom);
			lo = 8'($urandom);
			send_byte(index, 2 * w, hi);
			send_byte(index, 2 * w + 1, lo);
			wait_host_wait(1'b1, 1, "host_wait to rise after an odd byte");
			model[word_index(region_of(index), w)] = {hi, lo};
		end
		wait_host_wait(1'b0, WAIT_FALL_CYCLES, "host_wait to fall after the last word");
		download = 1'b0;
		// drive flags follow the end of a disk download
		if (index == 8'd1 || index == 8'd2) begin
			cls = image_class(n_words);
			exp_inserted[index - 1] = cls[1];
			exp_sides[index - 1] = cls[0];
		end
		@(negedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic cpu_access(input logic [1:0] region, input int offset, input logic write,
		input logic [1:0] lanes, input logic byte_sel, input logic [15:0] wdata,
		output cpu_rsp_t rsp);
		int n;
		cpu_req.valid = 1'b1;
		cpu_req.write = write;
		cpu_req.region = region;
		cpu_req.offset = `MEM_OFFSET_BITS'(offset);
		cpu_req.byte_sel = byte_sel;
		cpu_req.lanes = lanes;
		cpu_req.wdata = wdata;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!cpu_rsp.ack && n < ACCESS_CYCLES);
		if (!cpu_rsp.ack)
			report_failure("no ack on the cpu port within the access timeout");
		rsp = cpu_rsp;
		cpu_req = '0;
	endtask

	task automatic read_expect(input string name, input logic [1:0] region, input int offset,
		input logic byte_sel, input logic [15:0] exp);
		cpu_rsp_t rsp;
		cpu_access(region, offset, 1'b0, 2'b11, byte_sel, 16'h0000, rsp);
		check_rsp(name, rsp, exp);
	endtask

	task automatic pulse_disk_ack();
		disk_ack = 1'b1;
		@(negedge clk_sys);
		disk_ack = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic pulse_osd_reset();
		host.osd_reset = 1'b1;
		@(negedge clk_sys);
		host.osd_reset = 1'b0;
	endtask

	// ====================================================================
	// tests
	// ====================================================================

	task automatic test_rom_download();
		cpu_rsp_t rsp;
		int w;
		send_image(8'd0, 8);
		// first read also waits out the power-on hold
		for (w = 0; w < 8; w++)
			read_expect("cpu_rsp.rdata rom", `REGION_ROM, w, 1'b0,
				model[word_index(`REGION_ROM, w)]);
		// rom is read only for the cpu
		cpu_access(`REGION_ROM, 2, 1'b1, 2'b11, 1'b0,
			~model[word_index(`REGION_ROM, 2)], rsp);
		read_expect("cpu_rsp.rdata rom after write", `REGION_ROM, 2, 1'b0,
			model[word_index(`REGION_ROM, 2)]);
	endtask

	task automatic test_image_class();
		send_image(8'd1, `DISK_DS_WORDS);
		check_flags("disk_inserted", disk_inserted, exp_inserted);
		check_flags("disk_sides", disk_sides, exp_sides);
		send_image(8'd2, `DISK_SS_WORDS);
		check_flags("disk_inserted", disk_inserted, exp_inserted);
		check_flags("disk_sides", disk_sides, exp_sides);
		// three words is no known image size
		send_image(8'd1, 3);
		check_flags("disk_inserted", disk_inserted, exp_inserted);
		check_flags("disk_sides", disk_sides, exp_sides);
		disk.eject = 2'b10;
		@(negedge clk_sys);
		disk.eject = 2'b00;
		exp_inserted[1] = 1'b0;
		exp_sides[1] = 1'b0;
		@(negedge clk_sys);
		check_flags("disk_inserted", disk_inserted, exp_inserted);
		check_flags("disk_sides", disk_sides, exp_sides);
	endtask

	task automatic test_ram_disk();
		cpu_rsp_t rsp;
		logic [15:0] data;
		logic [15:0] word;
		int offsets [6];
		logic [1:0] regions [6];
		int i;
		data = 16'($urandom);
		cpu_access(`REGION_RAM, 10, 1'b1, 2'b11, 1'b0, data, rsp);
		model[word_index(`REGION_RAM, 10)] = data;
		// upper lane only, then lower lane only
		data = 16'($urandom);
		cpu_access(`REGION_RAM, 10, 1'b1, 2'b10, 1'b0, data, rsp);
		model[word_index(`REGION_RAM, 10)] =
			merge_lanes(model[word_index(`REGION_RAM, 10)], data, 2'b10);
		read_expect("cpu_rsp.rdata ram upper", `REGION_RAM, 10, 1'b0,
			model[word_index(`REGION_RAM, 10)]);
		data = 16'($urandom);
		cpu_access(`REGION_RAM, 10, 1'b1, 2'b01, 1'b0, data, rsp);
		model[word_index(`REGION_RAM, 10)] =
			merge_lanes(model[word_index(`REGION_RAM, 10)], data, 2'b01);
		read_expect("cpu_rsp.rdata ram lower", `REGION_RAM, 10, 1'b0,
			model[word_index(`REGION_RAM, 10)]);
		// disk words go out as one byte on both lanes
		offsets = '{0, 1, 300, `DISK_DS_WORDS - 1, 0, `DISK_SS_WORDS - 1};
		regions = '{`REGION_DISK_INT, `REGION_DISK_INT, `REGION_DISK_INT,
			`REGION_DISK_INT, `REGION_DISK_EXT, `REGION_DISK_EXT};
		for (i = 0; i < 6; i++) begin
			word = model[word_index(regions[i], offsets[i])];
			read_expect("cpu_rsp.rdata disk high", regions[i], offsets[i], 1'b0,
				{word[15:8], word[15:8]});
			read_expect("cpu_rsp.rdata disk low", regions[i], offsets[i], 1'b1,
				{word[7:0], word[7:0]});
		end
	endtask

	task automatic test_reset_gating();
		int n;
		pulse_osd_reset();
		cpu_req.valid = 1'b1;
		cpu_req.write = 1'b0;
		cpu_req.region = `REGION_RAM;
		cpu_req.offset = `MEM_OFFSET_BITS'(10);
		cpu_req.lanes = 2'b11;
		n = 0;
		// held request must wait out the whole hold
		while (n < `RESET_HOLD * `SLOT_CYCLES) begin
			@(negedge clk_sys);
			n++;
			if (cpu_rsp.ack)
				report_failure("cpu request was acked while the reset hold was running");
		end
		while (!cpu_rsp.ack && n < ACCESS_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		if (!cpu_rsp.ack)
			report_failure("held cpu request got no ack after the reset hold");
		check_rsp("cpu_rsp.rdata after reset", cpu_rsp, model[word_index(`REGION_RAM, 10)]);
		cpu_req = '0;
	endtask

	task automatic test_turbo_delay();
		int i;
		int n;
		host.turbo_request = 1'b1;
		repeat (2 * `SLOT_CYCLES) @(negedge clk_sys);
		check_level("turbo_active", turbo_active, 1'b0);
		for (i = 0; i < `TURBO_ACK_HOLD - 1; i++)
			pulse_disk_ack();
		repeat (2 * `SLOT_CYCLES) @(negedge clk_sys);
		check_level("turbo_active", turbo_active, 1'b0);
		pulse_disk_ack();
		n = 0;
		while (!turbo_active && n < 2 * `SLOT_CYCLES + 2) begin
			@(negedge clk_sys);
			n++;
		end
		if (!turbo_active)
			report_failure("turbo_active did not rise after the last disk ack");
		// a new reset restarts the delay and motor activity skips it
		pulse_osd_reset();
		@(negedge clk_sys);
		check_level("turbo_active", turbo_active, 1'b0);
		disk.motor = 2'b01;
		n = 0;
		while (!turbo_active && n < ACCESS_CYCLES) begin
			@(negedge clk_sys);
			n++;
		end
		if (!turbo_active)
			report_failure("turbo_active did not rise with a floppy motor on");
		disk.motor = 2'b00;
		host.turbo_request = 1'b0;
		repeat (2 * `SLOT_CYCLES) @(negedge clk_sys);
		check_level("turbo_active", turbo_active, 1'b0);
	endtask

	task automatic test_led();
		int n;
		int high;
		download = 1'b1;
		@(negedge clk_sys);
		check_level("led_user", led_user, 1'b1);
		download = 1'b0;
		@(negedge clk_sys);
		check_level("led_user", led_user, 1'b0);
		disk.act = 2'b01;
		@(negedge clk_sys);
		disk.act = 2'b00;
		n = 1;
		while (!led_user && n < 3) begin
			@(negedge clk_sys);
			n++;
		end
		if (!led_user)
			report_failure("led_user did not rise after an act pulse");
		high = 0;
		while (led_user && n < `DISK_ACT_HOLD + 4) begin
			@(negedge clk_sys);
			n++;
			high++;
		end
		if (led_user || n > `DISK_ACT_HOLD + 2)
			report_failure("led_user did not fall in time after an act pulse");
		if (high < `DISK_ACT_HOLD)
			report_failure("led_user fell before the activity hold ended");
		// motor on inverts the activity indication
		disk.motor = 2'b10;
		@(negedge clk_sys);
		check_level("led_user", led_user, 1'b1);
		disk.act = 2'b10;
		@(negedge clk_sys);
		disk.act = 2'b00;
		repeat (3) @(negedge clk_sys);
		check_level("led_user", led_user, 1'b0);
		disk.motor = 2'b00;
		@(negedge clk_sys);
		check_level("led_user", led_user, 1'b1);
		repeat (`DISK_ACT_HOLD + 2) @(negedge clk_sys);
		check_level("led_user", led_user, 1'b0);
	endtask

	// ====================================================================
	// main sequence
	// ====================================================================

	initial begin
		clk_sys = 1'b0;
		n_reset = 1'b0;
		dl = '0;
		download = 1'b0;
		cpu_req = '0;
		host.osd_reset = 1'b0;
		host.user_button = 1'b0;
		host.cpu_reset_out = 1'b1;
		host.turbo_request = 1'b0;
		disk = '0;
		disk_ack = 1'b0;
		exp_inserted = 2'b00;
		exp_sides = 2'b00;
		void'($urandom(67));
		repeat (16) @(negedge clk_sys);
		n_reset = 1'b1;
		@(negedge clk_sys);
		test_rom_download();
		test_image_class();
		test_ram_disk();
		test_reset_gating();
		test_turbo_delay();
		test_led();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
